// File: files.f
hw/oflow_buffer_pkg.sv
hw/oflow_fsm_core.sv
hw/oflow_end_pointer_table.sv
hw/oflow_fsm_buffer_write.sv
hw/oflow_mem_buffer.sv
hw/oflow_buffer_top.sv
testbench/oflow_buffer_tb.sv

// File: testbench/oflow_buffer_tb.sv
// frame history buffer testbench
module oflow_buffer_tb;

	import oflow_buffer_pkg::*;

	localparam int WAIT_LIMIT = 1000;          // cycles per handshake wait

	logic clk;
	logic reset_N;
	logic frame_req;
	logic [TOTAL_FRAME_NUM_WIDTH-1:0] frame_num;
	logic [NUM_OF_HISTORY_FRAMES_WIDTH-1:0] num_of_history_frames;
	logic [ADDR_WIDTH-1:0] frame_len;
	logic frame_ack;
	logic pix_req;
	logic [PAIR_WIDTH-1:0] pix_pair;
	logic pix_ack;
	logic rd_en;
	logic [SLOT_WIDTH-1:0] rd_slot;
	logic [OFFSET_WIDTH-1:0] rd_offset;
	logic [PAIR_WIDTH-1:0] rd_data;

	// shadow of the history slots
	logic [PIXEL_WIDTH-1:0] model_pix [MAX_HISTORY_FRAMES][SLOT_DEPTH];
	int slot_len [MAX_HISTORY_FRAMES];         // valid pixels per slot
	int error_count;
	int frames_sent;
	int pairs_read;

	// monitor state
	logic frame_seen;                          // first frame_req seen
	logic frame_req_d;
	logic frame_ack_d;
	logic pix_ack_d;
	logic frame_closed;                        // frame_ack seen this frame
	int pairs_acked;

	oflow_buffer_top u_oflow_buffer_top (
		.clk                   (clk),
		.reset_N               (reset_N),
		.frame_req             (frame_req),
		.frame_num             (frame_num),
		.num_of_history_frames (num_of_history_frames),
		.frame_len             (frame_len),
		.frame_ack             (frame_ack),
		.pix_req               (pix_req),
		.pix_pair              (pix_pair),
		.pix_ack               (pix_ack),
		.rd_en                 (rd_en),
		.rd_slot               (rd_slot),
		.rd_offset             (rd_offset),
		.rd_data               (rd_data)
	);

	always #50 clk = ~clk;                     // 100 unit period

	task automatic report_mismatch(input string name, input int exp, input int act);
		error_count++;
		$display("CHECK FAILED %s expected %0h actual %0h", name, exp, act);
	endtask

	task automatic print_counts();
		$display("frames sent %0d, pairs read %0d, errors %0d",
			frames_sent, pairs_read, error_count);
	endtask

	task automatic stop_on_timeout(input string what);
		$display("timeout while waiting for %s", what);
		print_counts();
		$display("Test failures found");
		$finish;
	endtask

	// ----------------------------------------
	// protocol checks
	// ----------------------------------------
	always @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			frame_seen <= 1'b0;
		end else if (frame_req) begin
			frame_seen <= 1'b1;
		end
	end

	reset_frame_ack_chk: assert property (@(posedge clk) disable iff (!reset_N)
		!frame_seen |-> !frame_ack)
		else report_mismatch("frame_ack low before first frame", 0, 1);
	reset_pix_ack_chk: assert property (@(posedge clk) disable iff (!reset_N)
		!frame_seen |-> !pix_ack)
		else report_mismatch("pix_ack low before first frame", 0, 1);
	frame_ack_fall_chk: assert property (@(posedge clk) disable iff (!reset_N)
		$fell(frame_ack) |-> !$past(frame_req))
		else report_mismatch("frame_ack falls after frame_req low", 0, 1);
	pix_ack_fall_chk: assert property (@(posedge clk) disable iff (!reset_N)
		$fell(pix_ack) |-> !$past(pix_req))
		else report_mismatch("pix_ack falls after pix_req low", 0, 1);
	frame_ack_rise_chk: assert property (@(posedge clk) disable iff (!reset_N)
		$rose(frame_ack) |-> $past(frame_req))
		else report_mismatch("frame_ack rises with frame_req high", 1, 0);
	pix_ack_rise_chk: assert property (@(posedge clk) disable iff (!reset_N)
		$rose(pix_ack) |-> $past(pix_req))
		else report_mismatch("pix_ack rises with pix_req high", 1, 0);

	// pair count per frame, sampled mid cycle
	always @(negedge clk) begin
		if (reset_N) begin
			if (frame_req && !frame_req_d) begin   // new frame
				pairs_acked = 0;
				frame_closed = 1'b0;
			end
			if (pix_ack && !pix_ack_d) begin
				assert (!frame_closed)
					else report_mismatch("no pix_ack after frame_ack", 0, 1);
				pairs_acked++;
			end
			if (frame_ack && !frame_ack_d) begin
				assert (pairs_acked == int'(frame_len) / 2)
					else report_mismatch("pairs per frame", int'(frame_len) / 2, pairs_acked);
				frame_closed = 1'b1;
			end
		end
		frame_req_d = frame_req;
		frame_ack_d = frame_ack;
		pix_ack_d = pix_ack;
	end

	// ----------------------------------------
	// handshake waits
	// ----------------------------------------
	task automatic wait_pix_ack(input logic level);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (pix_ack !== level && cycles < WAIT_LIMIT) begin
			cycles++;
			@(negedge clk);
		end
		if (pix_ack !== level) stop_on_timeout("pix_ack");
	endtask

	task automatic wait_frame_ack(input logic level);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (frame_ack !== level && cycles < WAIT_LIMIT) begin
			cycles++;
			@(negedge clk);
		end
		if (frame_ack !== level) stop_on_timeout("frame_ack");
	endtask

	task automatic send_pair(input logic [PAIR_WIDTH-1:0] pair);
		@(posedge clk);
		pix_pair <= pair;
		pix_req <= 1'b1;
		wait_pix_ack(1'b1);
		@(posedge clk);
		pix_req <= 1'b0;                       // return to zero
		wait_pix_ack(1'b0);
	endtask

	// every pair of a slot, one cycle read latency
	task automatic read_slot(input int slot);
		logic [PAIR_WIDTH-1:0] expect_pair;
		for (int off = 0; off < slot_len[slot]; off += 2) begin
			@(posedge clk);
			rd_en <= 1'b1;
			rd_slot <= SLOT_WIDTH'(slot);
			rd_offset <= OFFSET_WIDTH'(off);
			@(posedge clk);
			rd_en <= 1'b0;
			@(negedge clk);                    // data registered one edge after rd_en
			expect_pair = {model_pix[slot][off+1], model_pix[slot][off]};
			pairs_read++;
			assert (rd_data === expect_pair)
				else report_mismatch($sformatf("readback slot %0d offset %0d", slot, off),
					expect_pair, rd_data);
		end
	endtask

	task automatic send_frame(input int num, input int hist);
		int len;
		int slot;
		int gap;
		logic [PAIR_WIDTH-1:0] pair;
		len = 2 * (1 + ($urandom % 32));      // even, 2..64
		slot = num % hist;
		@(posedge clk);
		frame_num <= TOTAL_FRAME_NUM_WIDTH'(num);
		num_of_history_frames <= NUM_OF_HISTORY_FRAMES_WIDTH'(hist);
		frame_len <= ADDR_WIDTH'(len);
		frame_req <= 1'b1;
		for (int i = 0; i < len / 2; i++) begin
			gap = $urandom % 5;                // idle cycles before the pair
			repeat (gap) @(posedge clk);
			pair = PAIR_WIDTH'($urandom);
			model_pix[slot][2*i] = pair[PIXEL_WIDTH-1:0];
			model_pix[slot][2*i+1] = pair[PAIR_WIDTH-1:PIXEL_WIDTH];
			send_pair(pair);
		end
		wait_frame_ack(1'b1);
		@(posedge clk);
		frame_req <= 1'b0;
		wait_frame_ack(1'b0);
		slot_len[slot] = len;
		frames_sent++;
		read_slot(slot);
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		void'($urandom(32'h81b8));
		clk = 1'b0;
		reset_N = 1'b0;
		frame_req = 1'b0;
		frame_num = '0;
		num_of_history_frames = '0;
		frame_len = '0;
		pix_req = 1'b0;
		pix_pair = '0;
		rd_en = 1'b0;
		rd_slot = '0;
		rd_offset = '0;
		error_count = 0;
		frames_sent = 0;
		pairs_read = 0;
		pairs_acked = 0;
		frame_closed = 1'b0;
		for (int s = 0; s < MAX_HISTORY_FRAMES; s++) begin
			slot_len[s] = 0;
		end
		repeat (5) @(posedge clk);
		reset_N <= 1'b1;
		repeat (4) @(posedge clk);             // acks stay low while idle
		for (int f = 0; f < 5; f++) begin
			send_frame(f, 5);                  // fill all five slots
		end
		for (int f = 0; f < 6; f++) begin
			send_frame(f, 3);                  // wraps over slots 0..2 twice
		end
		for (int s = 0; s < MAX_HISTORY_FRAMES; s++) begin
			read_slot(s);                      // slots 3 and 4 untouched
		end
		for (int f = 0; f < 6; f++) begin
			send_frame($urandom % 256, 1 + ($urandom % 5));
		end
		for (int s = 0; s < MAX_HISTORY_FRAMES; s++) begin
			read_slot(s);
		end
		repeat (2) @(posedge clk);
		print_counts();
		if (error_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: hw/oflow_buffer_top.sv
// frame history buffer top
module oflow_buffer_top (
	input  logic clk,
	input  logic reset_N,
	// frame handshake
	input  logic frame_req,
	input  logic [oflow_buffer_pkg::TOTAL_FRAME_NUM_WIDTH-1:0] frame_num,
	input  logic [oflow_buffer_pkg::NUM_OF_HISTORY_FRAMES_WIDTH-1:0] num_of_history_frames,
	input  logic [oflow_buffer_pkg::ADDR_WIDTH-1:0] frame_len,
	output logic frame_ack,
	// pixel handshake
	input  logic pix_req,
	input  logic [oflow_buffer_pkg::PAIR_WIDTH-1:0] pix_pair,
	output logic pix_ack,
	// history read port
	input  logic rd_en,
	input  logic [oflow_buffer_pkg::SLOT_WIDTH-1:0] rd_slot,
	input  logic [oflow_buffer_pkg::OFFSET_WIDTH-1:0] rd_offset,
	output logic [oflow_buffer_pkg::PAIR_WIDTH-1:0] rd_data
);

	import oflow_buffer_pkg::*;

	// ----------------------------------------
	// internal nets
	// ----------------------------------------
	logic load_frame;
	logic start_write;
	logic ready_from_core;
	logic done_write;
	logic we;                                   // to core and memory
	logic [PAIR_WIDTH-1:0] held_pair;
	logic [SLOT_WIDTH-1:0] cur_slot;
	logic [ADDR_WIDTH-1:0] end_pointers [MAX_HISTORY_FRAMES];
	logic [OFFSET_WIDTH-1:0] offset_0;
	logic [OFFSET_WIDTH-1:0] offset_1;

	// handshakes and frame sequencing
	oflow_fsm_core u_oflow_fsm_core (
		.clk             (clk),
		.reset_N         (reset_N),
		.frame_req       (frame_req),
		.frame_ack       (frame_ack),
		.pix_req         (pix_req),
		.pix_pair        (pix_pair),
		.pix_ack         (pix_ack),
		.we              (we),
		.done_write      (done_write),
		.load_frame      (load_frame),
		.start_write     (start_write),
		.ready_from_core (ready_from_core),
		.held_pair       (held_pair)
	);

	// slot choice and per slot lengths
	oflow_end_pointer_table u_oflow_end_pointer_table (
		.clk                   (clk),
		.reset_N               (reset_N),
		.load_frame            (load_frame),
		.frame_num             (frame_num),
		.num_of_history_frames (num_of_history_frames),
		.frame_len             (frame_len),
		.cur_slot              (cur_slot),
		.end_pointers          (end_pointers)
	);

	oflow_fsm_buffer_write u_oflow_fsm_buffer_write (
		.clk             (clk),
		.reset_N         (reset_N),
		.cur_slot        (cur_slot),
		.end_pointers    (end_pointers),
		.start_write     (start_write),
		.ready_from_core (ready_from_core),
		.done_write      (done_write),
		.we              (we),
		.offset_0        (offset_0),
		.offset_1        (offset_1)
	);

	// even and odd banks
	oflow_mem_buffer u_oflow_mem_buffer (
		.clk       (clk),
		.we        (we),
		.cur_slot  (cur_slot),
		.offset_0  (offset_0),
		.offset_1  (offset_1),
		.held_pair (held_pair),
		.rd_en     (rd_en),
		.rd_slot   (rd_slot),
		.rd_offset (rd_offset),
		.rd_data   (rd_data)
	);

endmodule

// File: hw/oflow_mem_buffer.sv
// two bank pixel history memory
module oflow_mem_buffer (
	input  logic clk,
	// pair write port
	input  logic we,
	input  logic [oflow_buffer_pkg::SLOT_WIDTH-1:0] cur_slot,
	input  logic [oflow_buffer_pkg::OFFSET_WIDTH-1:0] offset_0,   // even pixel
	input  logic [oflow_buffer_pkg::OFFSET_WIDTH-1:0] offset_1,   // odd pixel
	input  logic [oflow_buffer_pkg::PAIR_WIDTH-1:0] held_pair,
	// read port
	input  logic rd_en,
	input  logic [oflow_buffer_pkg::SLOT_WIDTH-1:0] rd_slot,
	input  logic [oflow_buffer_pkg::OFFSET_WIDTH-1:0] rd_offset,
	output logic [oflow_buffer_pkg::PAIR_WIDTH-1:0] rd_data
);

	import oflow_buffer_pkg::*;

	logic [PIXEL_WIDTH-1:0] even_bank [BANK_DEPTH];
	logic [PIXEL_WIDTH-1:0] odd_bank [BANK_DEPTH];
	logic [BANK_ADDR_WIDTH-1:0] even_addr;
	logic [BANK_ADDR_WIDTH-1:0] odd_addr;
	logic [BANK_ADDR_WIDTH-1:0] rd_addr;

	// bank row = slot * 32 + offset / 2
	function automatic logic [BANK_ADDR_WIDTH-1:0] pair_addr(
		input logic [SLOT_WIDTH-1:0] slot,
		input logic [OFFSET_WIDTH-1:0] offset
	);
		logic [BANK_ADDR_WIDTH-1:0] slot_base;
		slot_base = BANK_ADDR_WIDTH'(slot) * BANK_ADDR_WIDTH'(PAIRS_PER_SLOT);
		pair_addr = slot_base + BANK_ADDR_WIDTH'(offset >> 1);
	endfunction

	assign even_addr = pair_addr(cur_slot, offset_0);
	assign odd_addr = pair_addr(cur_slot, offset_1);   // same row as even
	assign rd_addr = pair_addr(rd_slot, rd_offset);

	// ----------------------------------------
	// write, both pixels in one cycle
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (we) begin
			even_bank[even_addr] <= held_pair[PIXEL_WIDTH-1:0];
			odd_bank[odd_addr] <= held_pair[PAIR_WIDTH-1:PIXEL_WIDTH];
		end
	end

	// ----------------------------------------
	// read, one cycle latency
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= {odd_bank[rd_addr], even_bank[rd_addr]};  // even pixel low
		end
	end

endmodule

// File: hw/oflow_fsm_buffer_write.sv
// frame write sequencer
module oflow_fsm_buffer_write (
	input  logic clk,
	input  logic reset_N,
	input  logic [oflow_buffer_pkg::SLOT_WIDTH-1:0] cur_slot,
	input  logic [oflow_buffer_pkg::ADDR_WIDTH-1:0]
		end_pointers [oflow_buffer_pkg::MAX_HISTORY_FRAMES],
	input  logic start_write,          // from core, one cycle after load
	input  logic ready_from_core,      // holding reg has a pair
	output logic done_write,           // pulse back to core
	output logic we,                   // pair write strobe
	output logic [oflow_buffer_pkg::OFFSET_WIDTH-1:0] offset_0,
	output logic [oflow_buffer_pkg::OFFSET_WIDTH-1:0] offset_1
);

	import oflow_buffer_pkg::*;

	typedef enum logic [1:0] {
		idle_st,
		offset_st,
		wait_st
	} wr_state_t;

	wr_state_t state;
	wr_state_t next_state;
	logic [OFFSET_WIDTH-1:0] counter_offset;   // even pixel offset in slot
	logic [ADDR_WIDTH-1:0] end_ptr;
	logic below_end;

	assign end_ptr = end_pointers[cur_slot];   // slot latched at load time
	assign below_end = (counter_offset < end_ptr);

	// ----------------------------------------
	// state reg
	// ----------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state <= idle_st;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		done_write = 1'b0;
		we = 1'b0;
		case (state)
			idle_st: begin
				if (start_write) begin
					next_state = offset_st;
				end
			end
			offset_st: begin
				if (below_end && ready_from_core) begin
					we = 1'b1;                 // store pair, stay for the next
				end else if (below_end) begin
					next_state = wait_st;      // host is slow
				end else begin
					done_write = 1'b1;         // end pointer reached
					next_state = idle_st;
				end
			end
			wait_st: begin
				if (ready_from_core) begin
					next_state = offset_st;
				end
			end
			default: begin
				next_state = idle_st;
			end
		endcase
	end

	// ----------------------------------------
	// offset counter, steps one pair per write
	// ----------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			counter_offset <= '0;
		end else if (state == idle_st) begin
			counter_offset <= '0;
		end else if (we) begin
			counter_offset <= counter_offset + OFFSET_WIDTH'(2);
		end
	end

	assign offset_0 = counter_offset;
	assign offset_1 = counter_offset + OFFSET_WIDTH'(1);  // odd pixel of the pair

endmodule

// File: hw/oflow_end_pointer_table.sv
// history slot end pointers
module oflow_end_pointer_table (
	input  logic clk,
	input  logic reset_N,
	input  logic load_frame,           // one cycle pulse from core
	input  logic [oflow_buffer_pkg::TOTAL_FRAME_NUM_WIDTH-1:0] frame_num,
	input  logic [oflow_buffer_pkg::NUM_OF_HISTORY_FRAMES_WIDTH-1:0] num_of_history_frames,
	input  logic [oflow_buffer_pkg::ADDR_WIDTH-1:0] frame_len,
	output logic [oflow_buffer_pkg::SLOT_WIDTH-1:0] cur_slot,
	output logic [oflow_buffer_pkg::ADDR_WIDTH-1:0]
		end_pointers [oflow_buffer_pkg::MAX_HISTORY_FRAMES]
);

	import oflow_buffer_pkg::*;

	logic [TOTAL_FRAME_NUM_WIDTH-1:0] slot_mod;    // full width remainder
	logic [SLOT_WIDTH-1:0] next_slot;

	// ----------------------------------------
	// slot select
	// ----------------------------------------
	// host keeps the history count in 1..5 so the remainder fits a slot
	assign slot_mod = frame_num % num_of_history_frames;
	assign next_slot = slot_mod[SLOT_WIDTH-1:0];

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			cur_slot <= '0;
		end else if (load_frame) begin
			cur_slot <= next_slot;
		end
	end

	// ----------------------------------------
	// end pointer regs
	// ----------------------------------------
	// older slots keep the lengths of the frames still held there
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			for (int i = 0; i < MAX_HISTORY_FRAMES; i++) begin
				end_pointers[i] <= '0;
			end
		end else if (load_frame) begin
			for (int i = 0; i < MAX_HISTORY_FRAMES; i++) begin
				if (next_slot == SLOT_WIDTH'(i)) begin
					end_pointers[i] <= frame_len;  // only the selected slot
				end
			end
		end
	end

endmodule

// File: hw/oflow_fsm_core.sv
// frame and pixel handshake control
module oflow_fsm_core (
	input  logic clk,
	input  logic reset_N,
	// frame handshake
	input  logic frame_req,
	output logic frame_ack,
	// pixel handshake
	input  logic pix_req,
	input  logic [oflow_buffer_pkg::PAIR_WIDTH-1:0] pix_pair,
	output logic pix_ack,
	// write fsm side
	input  logic we,                   // pair leaves holding reg this cycle
	input  logic done_write,           // frame fully stored
	output logic load_frame,           // to end pointer table
	output logic start_write,          // kicks the write fsm
	output logic ready_from_core,      // holding reg full
	output logic [oflow_buffer_pkg::PAIR_WIDTH-1:0] held_pair
);

	typedef enum logic [2:0] {
		idle_st,
		load_st,
		write_st,
		ack_st,
		release_st
	} core_state_t;

	core_state_t state;
	core_state_t next_state;
	logic take_pair;                   // latch a new pair into holding reg

	// ----------------------------------------
	// frame fsm
	// ----------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state <= idle_st;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			idle_st: begin
				if (frame_req) begin           // host values already stable
					next_state = load_st;
				end
			end
			load_st: begin
				next_state = write_st;         // slot and end pointer latched here
			end
			write_st: begin
				if (done_write) begin
					next_state = ack_st;
				end
			end
			ack_st: begin
				if (!frame_req) begin          // ack drops next cycle
					next_state = release_st;
				end
			end
			release_st: begin
				next_state = idle_st;
			end
			default: begin
				next_state = idle_st;
			end
		endcase
	end

	assign load_frame = (state == load_st);
	assign frame_ack = (state == ack_st);

	// start one cycle behind load so the table is settled
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			start_write <= 1'b0;
		end else begin
			start_write <= load_frame;
		end
	end

	// ----------------------------------------
	// pixel handshake and holding reg
	// ----------------------------------------
	// only accept while a frame is being written, and only after the
	// previous four-phase cycle has fully returned to zero
	assign take_pair = (state == write_st) && pix_req && !pix_ack && !ready_from_core;

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			ready_from_core <= 1'b0;
			pix_ack <= 1'b0;
		end else begin
			if (we) begin
				ready_from_core <= 1'b0;       // pair went to memory
			end else if (take_pair) begin
				ready_from_core <= 1'b1;
			end
			if (we) begin
				pix_ack <= 1'b1;               // ack once the pair is stored
			end else if (pix_ack && !pix_req) begin
				pix_ack <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take_pair) begin
			held_pair <= pix_pair;
		end
	end

endmodule

// File: hw/oflow_buffer_pkg.sv
// optical flow history buffer definitions
package oflow_buffer_pkg;

	// ----------------------------------------
	// pixel and frame numbering
	// ----------------------------------------
	localparam int PIXEL_WIDTH = 8;                  // one pixel
	localparam int PAIR_WIDTH = 2 * PIXEL_WIDTH;     // even pixel in low byte
	localparam int TOTAL_FRAME_NUM_WIDTH = 8;        // frame serial 0..255
	localparam int MAX_HISTORY_FRAMES = 5;           // number of history slots
	localparam int NUM_OF_HISTORY_FRAMES_WIDTH = 3;  // history count 1..5

	// ----------------------------------------
	// slot geometry
	// ----------------------------------------
	localparam int SLOT_WIDTH = 3;                   // slot index 0..4
	localparam int OFFSET_WIDTH = 7;                 // holds 64 itself
	localparam int ADDR_WIDTH = OFFSET_WIDTH;        // end pointer width
	localparam int SLOT_DEPTH = 64;                  // pixels per slot
	localparam int PAIRS_PER_SLOT = SLOT_DEPTH / 2;  // rows per slot in one bank

	// ----------------------------------------
	// bank geometry
	// ----------------------------------------
	localparam int BANK_ADDR_WIDTH = 8;              // 5 slots x 32 pairs
	localparam int BANK_DEPTH = MAX_HISTORY_FRAMES * PAIRS_PER_SLOT;

endpackage
